// File: include/mp_sys_cfg.svh
//////////////////////////////////////////////////////////////////////
// System configuration for the memory side of the many-core system
// Widths, L2 banking, memory map and core count
//////////////////////////////////////////////////////////////////////
`ifndef MP_SYS_CFG_SVH
`define MP_SYS_CFG_SVH

// Bus widths
`define MP_ADDR_W      32
`define MP_DATA_W      32
`define MP_STRB_W      4

// L2 is word interleaved over the banks
`define MP_NUM_BANKS   4
`define MP_BANK_WORDS  256
`define MP_L2_SIZE     (`MP_NUM_BANKS * `MP_BANK_WORDS * `MP_STRB_W)

// Memory map
`define MP_L2_BASE     32'h8000_0000
`define MP_CTRL_BASE   32'h4000_0000
`define MP_ROM_BASE    32'hA000_0000
`define MP_PERIPH_WIN  32'h0001_0000  // 64 KiB for ROM and control regs

`define MP_NUM_CORES   8

`endif

// File: hdl/mp_sys_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types: address views, target select and boot ROM image
//////////////////////////////////////////////////////////////////////
`include "mp_sys_cfg.svh"

package mp_sys_pkg;

  localparam int unsigned OFFS_W    = $clog2(`MP_STRB_W);
  localparam int unsigned BANK_W    = $clog2(`MP_NUM_BANKS);
  localparam int unsigned WORD_W    = $clog2(`MP_BANK_WORDS);
  localparam int unsigned REG_IDX_W = $clog2(`MP_PERIPH_WIN) - OFFS_W;

  // L2 view: word interleaving puts the bank right above the byte offset
  typedef struct packed {
    logic [`MP_ADDR_W-WORD_W-BANK_W-OFFS_W-1:0] region;
    logic [WORD_W-1:0]                          word;
    logic [BANK_W-1:0]                          bank;
    logic [OFFS_W-1:0]                          offset;
  } l2_view_t;

  typedef struct packed {
    logic [`MP_ADDR_W-REG_IDX_W-OFFS_W-1:0] region;
    logic [REG_IDX_W-1:0]                   idx;     // Word index in the window
    logic [OFFS_W-1:0]                      offset;
  } reg_view_t;

  typedef union packed {
    l2_view_t  l2;
    reg_view_t regs;
  } mp_addr_u;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_ROM,
    TGT_CTRL,
    TGT_NONE
  } mp_target_e;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Word indices, byte offsets 0, 4 and 8
  localparam reg_idx_t REG_EOC       = 'd0;
  localparam reg_idx_t REG_WAKE_UP   = 'd1;
  localparam reg_idx_t REG_NUM_CORES = 'd2;

  // Boot loop: jump to L2 base after wfi
  localparam int unsigned ROM_DEPTH = 4;
  localparam logic [`MP_DATA_W-1:0] ROM_WORDS [ROM_DEPTH] = '{
    32'h8000_02b7,  // lui  t0, 0x80000
    32'h1050_0073,  // wfi
    32'h0002_8067,  // jr   t0
    32'h0000_0013   // nop
  };

endpackage : mp_sys_pkg

// File: hdl/mem_req_if.sv
//////////////////////////////////////////////////////////////////////
// Decoded request from the decode stage to the storage stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

interface mem_req_if
  import mp_sys_pkg::*;
();

  logic                  valid;   // One request per high cycle
  logic                  we;
  mp_addr_u              addr;
  logic [`MP_DATA_W-1:0] wdata;
  logic [`MP_STRB_W-1:0] strb;
  mp_target_e            target;

  modport src (
    output valid, we, addr, wdata, strb, target
  );

  modport dst (
    input  valid, we, addr, wdata, strb, target
  );

endinterface : mem_req_if

// File: hdl/addr_decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Stage 1: address decode against the memory map
// Classifies each request and registers it with its target
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module addr_decode_stage
  import mp_sys_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`MP_ADDR_W-1:0] addr_i,
  input  logic [`MP_DATA_W-1:0] wdata_i,
  input  logic [`MP_STRB_W-1:0] strb_i,
  mem_req_if.src                req_o
);

  mp_target_e target;

  // Wrapping subtraction gives a single compare per window
  function automatic logic in_window(input logic [`MP_ADDR_W-1:0] addr,
                                     input logic [`MP_ADDR_W-1:0] base,
                                     input logic [`MP_ADDR_W-1:0] size);
    logic [`MP_ADDR_W-1:0] rel;
    rel = addr - base;
    return rel < size;
  endfunction

  always_comb begin
    if (in_window(addr_i, `MP_L2_BASE, `MP_L2_SIZE))
      target = TGT_L2;
    else if (in_window(addr_i, `MP_ROM_BASE, `MP_PERIPH_WIN))
      target = TGT_ROM;
    else if (in_window(addr_i, `MP_CTRL_BASE, `MP_PERIPH_WIN))
      target = TGT_CTRL;
    else
      target = TGT_NONE;  // Unmapped, answered with an error
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_o.valid <= 1'b0;
    end else begin
      req_o.valid <= req_i;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      req_o.we     <= we_i;
      req_o.addr   <= addr_i;
      req_o.wdata  <= wdata_i;
      req_o.strb   <= strb_i;
      req_o.target <= target;
    end
  end

  a_target_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_o.valid |-> !$isunknown(req_o.target));

endmodule : addr_decode_stage

// File: hdl/l2_bank_array.sv
//////////////////////////////////////////////////////////////////////
// Word-interleaved L2 memory
// One synchronous SRAM per bank with byte strobes and registered read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module l2_bank_array
  import mp_sys_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  mem_req_if.dst                req_i,
  output logic [`MP_DATA_W-1:0] rdata_o
);

  localparam int unsigned BYTE_W = `MP_DATA_W / `MP_STRB_W;

  logic                                        l2_hit;
  logic [`MP_NUM_BANKS-1:0]                    bank_en;
  logic [`MP_NUM_BANKS-1:0][`MP_DATA_W-1:0]    bank_rdata;
  logic [BANK_W-1:0]                           bank_sel_q;

  assign l2_hit = req_i.valid && (req_i.target == TGT_L2);

  // Only the addressed bank sees the request
  always_comb begin
    bank_en = '0;
    bank_en[req_i.addr.l2.bank] = l2_hit;
  end

  for (genvar b = 0; b < `MP_NUM_BANKS; b++) begin : gen_bank
    logic [`MP_DATA_W-1:0] mem [`MP_BANK_WORDS];
    logic [`MP_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_en[b]) begin
        if (req_i.we) begin
          for (int i = 0; i < `MP_STRB_W; i++) begin
            if (req_i.strb[i])
              mem[req_i.addr.l2.word][i*BYTE_W +: BYTE_W] <= req_i.wdata[i*BYTE_W +: BYTE_W];
          end
        end else begin
          rdata_q <= mem[req_i.addr.l2.word];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Remember which bank answers in the next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bank_sel_q <= '0;
    end else if (l2_hit) begin
      bank_sel_q <= req_i.addr.l2.bank;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

  a_one_bank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(bank_en));

endmodule : l2_bank_array

// File: hdl/periph_stage.sv
//////////////////////////////////////////////////////////////////////
// Boot ROM and control registers with registered read
// Also delays valid, we and target for the response merge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module periph_stage
  import mp_sys_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  mem_req_if.dst                  req_i,
  output logic [`MP_DATA_W-1:0]   rdata_o,
  output logic                    valid_o,
  output logic                    we_o,
  output mp_target_e              target_o,
  output logic [`MP_NUM_CORES-1:0] wake_up_o,
  output logic                    eoc_valid_o
);

  logic                  ctrl_wr;
  logic                  wake_wr;
  logic [`MP_DATA_W-1:0] eoc_q;
  logic [`MP_DATA_W-1:0] rd_word;

  assign ctrl_wr = req_i.valid && req_i.we && (req_i.target == TGT_CTRL);
  assign wake_wr = ctrl_wr && (req_i.addr.regs.idx == REG_WAKE_UP);

  always_comb begin
    rd_word = '0;
    case (req_i.target)
      TGT_ROM:  rd_word = ROM_WORDS[req_i.addr.regs.idx[$clog2(ROM_DEPTH)-1:0]];
      TGT_CTRL: begin
        if (req_i.addr.regs.idx == REG_EOC)
          rd_word = eoc_q;
        else if (req_i.addr.regs.idx == REG_NUM_CORES)
          rd_word = `MP_DATA_W'(`MP_NUM_CORES);
      end
      default:  rd_word = '0;  // Wake-up is write only
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o   <= 1'b0;
      wake_up_o <= '0;
      eoc_q     <= '0;
    end else begin
      valid_o   <= req_i.valid;
      wake_up_o <= wake_wr ? req_i.wdata[`MP_NUM_CORES-1:0] : '0;  // Single-cycle pulse
      if (ctrl_wr && (req_i.addr.regs.idx == REG_EOC))
        eoc_q <= req_i.wdata;  // Full word, strobes ignored
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      we_o     <= req_i.we;
      target_o <= req_i.target;
      rdata_o  <= rd_word;
    end
  end

  assign eoc_valid_o = eoc_q[0];

  a_wake_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|wake_up_o) ##1 (|wake_up_o) |-> $past(wake_wr, 1) && $past(wake_wr, 2));

endmodule : periph_stage

// File: hdl/resp_merge_stage.sv
//////////////////////////////////////////////////////////////////////
// Stage 3: response select, error rule and output registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module resp_merge_stage
  import mp_sys_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [`MP_DATA_W-1:0] l2_rdata_i,
  input  logic [`MP_DATA_W-1:0] periph_rdata_i,
  input  logic                  valid_i,
  input  logic                  we_i,
  input  mp_target_e            target_i,
  output logic                  rvalid_o,
  output logic                  err_o,
  output logic [`MP_DATA_W-1:0] rdata_o
);

  logic                  err;
  logic [`MP_DATA_W-1:0] sel_data;

  // Unmapped access or a write into the ROM
  assign err      = (target_i == TGT_NONE) || ((target_i == TGT_ROM) && we_i);
  assign sel_data = (target_i == TGT_L2) ? l2_rdata_i : periph_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= valid_i;
      err_o    <= valid_i && err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i)
      rdata_o <= (we_i || err) ? '0 : sel_data;  // Writes and errors return zero
  end

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_o |-> rvalid_o);

endmodule : resp_merge_stage

// File: hdl/mempool_lite_system.sv
//////////////////////////////////////////////////////////////////////
// Memory side of the many-core system: decode, L2, boot ROM, ctrl regs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module mempool_lite_system
  import mp_sys_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`MP_ADDR_W-1:0]    addr_i,
  input  logic [`MP_DATA_W-1:0]    wdata_i,
  input  logic [`MP_STRB_W-1:0]    strb_i,
  output logic                     rvalid_o,
  output logic [`MP_DATA_W-1:0]    rdata_o,
  output logic                     err_o,
  output logic [`MP_NUM_CORES-1:0] wake_up_o,
  output logic                     eoc_valid_o
);

  mem_req_if dec_req ();

  logic [`MP_DATA_W-1:0] l2_rdata;
  logic [`MP_DATA_W-1:0] periph_rdata;
  logic                  acc_valid;
  logic                  acc_we;
  mp_target_e            acc_target;

  addr_decode_stage i_addr_decode (
    .clk_i   (clk_i   ),
    .arst_n_i(arst_n_i),
    .req_i   (req_i   ),
    .we_i    (we_i    ),
    .addr_i  (addr_i  ),
    .wdata_i (wdata_i ),
    .strb_i  (strb_i  ),
    .req_o   (dec_req )
  );

  l2_bank_array i_l2_banks (
    .clk_i   (clk_i   ),
    .arst_n_i(arst_n_i),
    .req_i   (dec_req ),
    .rdata_o (l2_rdata)
  );

  periph_stage i_periph (
    .clk_i      (clk_i       ),
    .arst_n_i   (arst_n_i    ),
    .req_i      (dec_req     ),
    .rdata_o    (periph_rdata),
    .valid_o    (acc_valid   ),
    .we_o       (acc_we      ),
    .target_o   (acc_target  ),
    .wake_up_o  (wake_up_o   ),
    .eoc_valid_o(eoc_valid_o )
  );

  resp_merge_stage i_resp_merge (
    .clk_i         (clk_i       ),
    .arst_n_i      (arst_n_i    ),
    .l2_rdata_i    (l2_rdata    ),
    .periph_rdata_i(periph_rdata),
    .valid_i       (acc_valid   ),
    .we_i          (acc_we      ),
    .target_i      (acc_target  ),
    .rvalid_o      (rvalid_o    ),
    .err_o         (err_o       ),
    .rdata_o       (rdata_o     )
  );

endmodule : mempool_lite_system

// File: dv/mp_sys_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the memory side of the many-core system
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mp_sys_cfg.svh"

module mp_sys_tb
  import mp_sys_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned NUM_L2     = 12;
  localparam int unsigned L2_WORDS   = `MP_NUM_BANKS * `MP_BANK_WORDS;
  localparam int unsigned L2_BYTES   = L2_WORDS * 4;
  localparam int unsigned WIN_BYTES  = 32'h0001_0000;
  localparam int unsigned N_REQ      = 3 * NUM_L2 + 40;  // L2 phases plus ROM, unmapped, regs
  localparam int unsigned MARGIN     = 64;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     req_i;
  logic                     we_i;
  logic [`MP_ADDR_W-1:0]    addr_i;
  logic [`MP_DATA_W-1:0]    wdata_i;
  logic [`MP_STRB_W-1:0]    strb_i;
  logic                     rvalid_o;
  logic [`MP_DATA_W-1:0]    rdata_o;
  logic                     err_o;
  logic [`MP_NUM_CORES-1:0] wake_up_o;
  logic                     eoc_valid_o;

  integer                   seed;
  int unsigned              cyc;
  logic [`MP_DATA_W-1:0]    l2_model [L2_WORDS];
  logic [`MP_DATA_W-1:0]    eoc_model;
  logic [`MP_ADDR_W-1:0]    l2_addr [NUM_L2];

  // Expected responses, each tagged with the cycle it must show up in
  int unsigned              exp_due [$];
  logic [`MP_DATA_W-1:0]    exp_data [$];
  logic                     exp_err [$];
  int unsigned              wake_due [$];
  logic [`MP_NUM_CORES-1:0] wake_val [$];

  mempool_lite_system dut0 (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .strb_i     (strb_i     ),
    .rvalid_o   (rvalid_o   ),
    .rdata_o    (rdata_o    ),
    .err_o      (err_o      ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Memory map model, updates L2 and registers and returns the read data
  function automatic logic [`MP_DATA_W-1:0] ref_access(
      input  logic                     we,
      input  logic [`MP_ADDR_W-1:0]    addr,
      input  logic [`MP_DATA_W-1:0]    wdata,
      input  logic [`MP_STRB_W-1:0]    strb,
      output logic                     err,
      output logic [`MP_NUM_CORES-1:0] wake);
    logic [`MP_DATA_W-1:0] rd;
    int unsigned           widx;
    rd   = '0;
    err  = 1'b0;
    wake = '0;
    if ((addr - `MP_L2_BASE) < L2_BYTES) begin
      widx = (addr - `MP_L2_BASE) >> 2;
      if (we) begin
        for (int b = 0; b < `MP_STRB_W; b++)
          if (strb[b]) l2_model[widx][8*b +: 8] = wdata[8*b +: 8];
      end else begin
        rd = l2_model[widx];
      end
    end else if ((addr - `MP_ROM_BASE) < WIN_BYTES) begin
      if (we) err = 1'b1;  // ROM is read only
      else rd = ROM_WORDS[(addr >> 2) % 4];
    end else if ((addr - `MP_CTRL_BASE) < WIN_BYTES) begin
      widx = (addr - `MP_CTRL_BASE) >> 2;
      if (we && widx == 0) eoc_model = wdata;
      else if (we && widx == 1) wake = wdata[`MP_NUM_CORES-1:0];
      else if (!we && widx == 0) rd = eoc_model;
      else if (!we && widx == 2) rd = `MP_NUM_CORES;
    end else begin
      err = 1'b1;
    end
    return rd;
  endfunction

  // Drives one request for the coming edge and queues its expectation
  task automatic issue(input logic we, input logic [`MP_ADDR_W-1:0] addr,
                       input logic [`MP_DATA_W-1:0] wdata, input logic [`MP_STRB_W-1:0] strb);
    logic [`MP_DATA_W-1:0]    rd;
    logic                     err;
    logic [`MP_NUM_CORES-1:0] wake;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    strb_i  = strb;
    rd = ref_access(we, addr, wdata, strb, err, wake);
    exp_due.push_back(cyc + 3);  // Sampled at cyc+1, response registered two edges later
    exp_data.push_back(rd);
    exp_err.push_back(err);
    if (wake != '0) begin
      wake_due.push_back(cyc + 2);
      wake_val.push_back(wake);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle(input int unsigned n);
    req_i = 1'b0;
    we_i  = 1'b0;
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // Compare in the middle of the cycle, when the outputs are stable
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (exp_due.size() > 0 && exp_due[0] == cyc) begin
        assert (rvalid_o === 1'b1 && rdata_o === exp_data[0] && err_o === exp_err[0])
          else stop_on_error($sformatf(
            "mismatch at %0t: got rvalid=%b rdata=%h err=%b, expected rdata=%h err=%b",
            $time, rvalid_o, rdata_o, err_o, exp_data[0], exp_err[0]));
        void'(exp_due.pop_front());
        void'(exp_data.pop_front());
        void'(exp_err.pop_front());
      end else begin
        assert (rvalid_o === 1'b0 && err_o === 1'b0)
          else stop_on_error($sformatf("mismatch at %0t: response with no request due",
                                       $time));
      end
      if (wake_due.size() > 0 && wake_due[0] == cyc) begin
        assert (wake_up_o === wake_val[0])
          else stop_on_error($sformatf("mismatch at %0t: wake_up_o=%h, expected %h",
                                       $time, wake_up_o, wake_val[0]));
        void'(wake_due.pop_front());
        void'(wake_val.pop_front());
      end else begin
        assert (wake_up_o === '0)
          else stop_on_error($sformatf("mismatch at %0t: wake_up_o=%h outside a pulse",
                                       $time, wake_up_o));
      end
    end
  end

  initial begin
    #((N_REQ + RST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("The run timed out before all tests finished");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed      = 32'h8172_e863;
    cyc       = 0;
    eoc_model = '0;
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    strb_i    = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    // Quiet after reset
    idle(4);
    assert (eoc_valid_o === 1'b0)
      else stop_on_error($sformatf("mismatch at %0t: eoc_valid_o high after reset", $time));

    // L2: full words first, then strobed writes, then reads, back to back
    for (int i = 0; i < NUM_L2; i++)
      l2_addr[i] = `MP_L2_BASE + 4 * ({$random(seed)} % L2_WORDS) + {$random(seed)} % 4;
    for (int i = 0; i < NUM_L2; i++)
      issue(1'b1, l2_addr[i], $random(seed), 4'hf);
    for (int i = 0; i < NUM_L2; i++)
      issue(1'b1, l2_addr[i], $random(seed), $random(seed));
    for (int i = 0; i < NUM_L2; i++)
      issue(1'b0, l2_addr[i], '0, '0);

    // Boot ROM reads at several offsets, then a rejected write
    issue(1'b0, `MP_ROM_BASE + 32'h0, '0, '0);
    issue(1'b0, `MP_ROM_BASE + 32'h4, '0, '0);
    issue(1'b0, `MP_ROM_BASE + 32'h8, '0, '0);
    issue(1'b0, `MP_ROM_BASE + 32'hc, '0, '0);
    issue(1'b0, `MP_ROM_BASE + 32'h24, '0, '0);
    issue(1'b0, `MP_ROM_BASE + 32'hfffc, '0, '0);
    issue(1'b1, `MP_ROM_BASE + 32'h8, 32'hffff_ffff, 4'hf);

    // Unmapped, including an alias of an L2 word just past the end of L2
    issue(1'b0, 32'h0000_0100, '0, '0);
    issue(1'b1, l2_addr[0] + L2_BYTES, 32'hbad0_bad0, 4'hf);
    issue(1'b0, 32'hc000_0000, '0, '0);
    issue(1'b0, `MP_CTRL_BASE + WIN_BYTES, '0, '0);
    issue(1'b0, l2_addr[0], '0, '0);

    // Control registers
    issue(1'b0, `MP_CTRL_BASE + 32'h0, '0, '0);
    issue(1'b1, `MP_CTRL_BASE + 32'h0, 32'h0000_0001, 4'h1);
    issue(1'b0, `MP_CTRL_BASE + 32'h0, '0, '0);
    issue(1'b0, `MP_CTRL_BASE + 32'h8, '0, '0);
    issue(1'b1, `MP_CTRL_BASE + 32'h8, 32'hdead_beef, 4'hf);
    issue(1'b0, `MP_CTRL_BASE + 32'h8, '0, '0);
    issue(1'b1, `MP_CTRL_BASE + 32'h4, 32'h0000_00a5, 4'hf);
    idle(3);
    issue(1'b1, `MP_CTRL_BASE + 32'h4, 32'h0000_005a, 4'hf);
    issue(1'b1, `MP_CTRL_BASE + 32'h4, 32'h0000_0081, 4'hf);
    issue(1'b0, `MP_CTRL_BASE + 32'h4, '0, '0);
    issue(1'b0, `MP_CTRL_BASE + 32'h10, '0, '0);
    idle(6);

    assert (eoc_valid_o === eoc_model[0])
      else stop_on_error($sformatf("mismatch at %0t: eoc_valid_o=%b, expected %b",
                                   $time, eoc_valid_o, eoc_model[0]));
    $display("Result: PASSED");
    $finish;
  end

endmodule : mp_sys_tb

// File: filelist.f
+incdir+include
hdl/mp_sys_pkg.sv
hdl/mem_req_if.sv
hdl/addr_decode_stage.sv
hdl/l2_bank_array.sv
hdl/periph_stage.sv
hdl/resp_merge_stage.sv
hdl/mempool_lite_system.sv
dv/mp_sys_tb.sv
